/* Makefile */
# Verilator build and run of the vertical interpolation testbench

SRCS = all.f $(wildcard source/*.sv source/*.svh tests/*.sv tests/*.svh)

all: run

obj_dir/Vtmu_vpipe_tb: $(SRCS)
	verilator --binary --timing -Wno-fatal -f all.f --top-module tmu_vpipe_tb \
		-o Vtmu_vpipe_tb

run: obj_dir/Vtmu_vpipe_tb
	./obj_dir/Vtmu_vpipe_tb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module tmu_vpipe

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* all.f */
+incdir+source
+incdir+tests
source/tmu_pkg.sv
source/tmu_vdivops.sv
source/tmu_edge_interp.sv
source/tmu_vinterp.sv
source/tmu_clip.sv
source/tmu_vpipe.sv
tests/tmu_vpipe_tb.sv

/* source/tmu_clip.sv */
/*
 * One register stage that drops points outside the screen.
 * Off-screen points are accepted and discarded in the same cycle.
 * Bounds come from TMU_HRES and TMU_VRES.
 */
`timescale 1ns/1ns
`include "tmu_params.svh"

module tmu_clip import tmu_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic stb_i,
	output logic ack_o,
	input  fragment_t point,
	output logic stb_o,
	input  logic ack_i,
	output fragment_t frag,
	output logic busy
);

	logic full;
	logic on_screen;
	logic keep;

	// Negative coordinates show up as a set sign bit
	assign on_screen = ~point.x[`TMU_PIX_W-1]
		& ~point.y[`TMU_PIX_W-1]
		& (point.x < `TMU_HRES)
		& (point.y < `TMU_VRES);

	// Register free, or being drained this cycle
	assign ack_o = ~full | ack_i;
	assign keep = stb_i & ack_o & on_screen;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			full <= 1'b0;
		else if (ack_o)
			full <= stb_i & on_screen;
	end

	always_ff @(posedge sys_clk) begin
		if (keep)
			frag <= point;
	end

	assign stb_o = full;
	assign busy = full;

endmodule

/* source/tmu_edge_interp.sv */
/*
 * Error-accumulating interpolator along one edge.
 * Point k is init +/- floor(k*m/divisor), wrapping modulo 2^18.
 * divisor must stay constant between load and the last step.
 */
`timescale 1ns/1ns
`include "tmu_params.svh"

module tmu_edge_interp import tmu_pkg::*; (
	input  logic sys_clk,
	input  logic load,
	input  logic next_point,
	input  logic [`TMU_COORD_W-1:0] init,
	input  step_t step,
	input  logic [`TMU_SQH_W-1:0] divisor,
	output logic [`TMU_COORD_W-1:0] o
);

	localparam int ERR_W = `TMU_QR_W + 1;

	logic [ERR_W-1:0] err;
	logic [ERR_W-1:0] err_sum;
	logic [ERR_W-1:0] divisor_ext;
	logic correct;
	logic [`TMU_COORD_W-1:0] delta;

	assign divisor_ext = {{(ERR_W-`TMU_SQH_W){1'b0}}, divisor};

	// Remainder piles up until it is worth one more unit
	assign err_sum = err + {1'b0, step.r};
	assign correct = (err_sum >= divisor_ext);
	assign delta = {1'b0, step.q} + {{(`TMU_COORD_W-1){1'b0}}, correct};

	always_ff @(posedge sys_clk) begin
		if (load) begin
			o <= init;
			err <= '0;
		end else if (next_point) begin
			if (step.positive)
				o <= o + delta;
			else
				o <= o - delta;
			if (correct)
				err <= err_sum - divisor_ext;
			else
				err <= err_sum;
		end
	end

endmodule

/* source/tmu_params.svh */
/*
 * Widths and screen bounds for the vertical interpolation stage.
 * Quotients and remainders are one bit narrower than coordinates.
 * The clip bounds are fixed at build time.
 */
`ifndef TMU_PARAMS_SVH
`define TMU_PARAMS_SVH

// Texture coordinate width
`define TMU_COORD_W 18

// Divider quotient and remainder width
`define TMU_QR_W 17

// Square height and point counter width
`define TMU_SQH_W 11

// Signed destination pixel coordinates
`define TMU_PIX_W 12

// Visible screen area, points outside are dropped
`define TMU_HRES 640
`define TMU_VRES 480

`endif

/* source/tmu_pkg.sv */
/*
 * Types shared along the vertical interpolation chain.
 * Destination coordinates are signed; texture coordinates wrap modulo 2^18.
 */
`include "tmu_params.svh"

package tmu_pkg;

	// One mesh column as it enters the stage
	typedef struct packed {
		logic [`TMU_COORD_W-1:0] ax;
		logic [`TMU_COORD_W-1:0] ay;
		logic [`TMU_COORD_W-1:0] bx;
		logic [`TMU_COORD_W-1:0] by;
		logic [`TMU_COORD_W-1:0] cx;
		logic [`TMU_COORD_W-1:0] cy;
		logic [`TMU_COORD_W-1:0] dx;
		logic [`TMU_COORD_W-1:0] dy;
		logic signed [`TMU_PIX_W-1:0] drx;
		logic signed [`TMU_PIX_W-1:0] dry;
	} column_t;

	// Per-edge step, magnitude split into quotient and remainder
	typedef struct packed {
		logic positive;
		logic [`TMU_QR_W-1:0] q;
		logic [`TMU_QR_W-1:0] r;
	} step_t;

	// Divider results handed to the column walker
	typedef struct packed {
		logic [`TMU_COORD_W-1:0] ax;
		logic [`TMU_COORD_W-1:0] ay;
		logic [`TMU_COORD_W-1:0] bx;
		logic [`TMU_COORD_W-1:0] by;
		step_t cx;
		step_t cy;
		step_t dx;
		step_t dy;
		logic signed [`TMU_PIX_W-1:0] drx;
		logic signed [`TMU_PIX_W-1:0] dry;
	} interp_op_t;

	// One interpolated point, also the output fragment
	typedef struct packed {
		logic signed [`TMU_PIX_W-1:0] x;
		logic signed [`TMU_PIX_W-1:0] y;
		logic [`TMU_COORD_W-1:0] tsx;
		logic [`TMU_COORD_W-1:0] tsy;
		logic [`TMU_COORD_W-1:0] tex;
		logic [`TMU_COORD_W-1:0] tey;
	} fragment_t;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_e;

	typedef enum logic {
		WALK_IDLE,
		WALK_BUSY
	} walk_state_e;

endpackage

/* source/tmu_vdivops.sv */
/*
 * Four restoring dividers in lockstep, one quotient bit per cycle.
 * squareh must be nonzero and held while busy. Results for squareh = 1
 * with a -2^17 difference are not meaningful but are never stepped.
 */
`timescale 1ns/1ns
`include "tmu_params.svh"

module tmu_vdivops import tmu_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic stb_i,
	output logic ack_o,
	input  column_t col,
	input  logic [`TMU_SQH_W-1:0] squareh,
	output logic stb_o,
	input  logic ack_i,
	output interp_op_t op,
	output logic busy
);

	localparam int CNT_W = $clog2(`TMU_QR_W);
	localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`TMU_QR_W - 1);

	div_state_e state;
	logic [CNT_W-1:0] step_cnt;
	logic accept;

	logic [`TMU_COORD_W-1:0] diff [4];
	logic [`TMU_COORD_W-1:0] mag [4];
	logic [`TMU_SQH_W:0] trial [4];
	logic [`TMU_SQH_W-1:0] rem_next [4];
	logic [3:0] q_bit;

	logic [3:0] positive_r;
	logic [`TMU_QR_W-1:0] quot [4];
	logic [`TMU_SQH_W-1:0] rem [4];
	logic [`TMU_COORD_W-1:0] ax_r, ay_r, bx_r, by_r;
	logic signed [`TMU_PIX_W-1:0] drx_r, dry_r;

	assign ack_o = (state == DIV_IDLE);
	assign stb_o = (state == DIV_DONE);
	assign busy = (state != DIV_IDLE);
	assign accept = stb_i & ack_o;

	always_comb begin
		// Vertical edge differences, left edge then right edge
		diff[0] = col.cx - col.ax;
		diff[1] = col.cy - col.ay;
		diff[2] = col.dx - col.bx;
		diff[3] = col.dy - col.by;
		for (int i = 0; i < 4; i++) begin
			mag[i] = diff[i][`TMU_COORD_W-1] ? -diff[i] : diff[i];
			trial[i] = {rem[i], quot[i][`TMU_QR_W-1]};
			if (trial[i] >= {1'b0, squareh}) begin
				rem_next[i] = trial[i][`TMU_SQH_W-1:0] - squareh;
				q_bit[i] = 1'b1;
			end else begin
				rem_next[i] = trial[i][`TMU_SQH_W-1:0];
				q_bit[i] = 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= DIV_IDLE;
			step_cnt <= '0;
		end else begin
			case (state)
				DIV_IDLE: if (accept) begin
					state <= DIV_RUN;
					step_cnt <= '0;
				end
				DIV_RUN: begin
					step_cnt <= step_cnt + 1'b1;
					if (step_cnt == LAST_STEP)
						state <= DIV_DONE;
				end
				DIV_DONE: if (ack_i)
					state <= DIV_IDLE;
				default: state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			for (int i = 0; i < 4; i++) begin
				positive_r[i] <= ~diff[i][`TMU_COORD_W-1];
				// Magnitude MSB preloads the remainder, leaving 17 bits to shift
				rem[i] <= {{(`TMU_SQH_W-1){1'b0}}, mag[i][`TMU_COORD_W-1]};
				quot[i] <= mag[i][`TMU_QR_W-1:0];
			end
			ax_r <= col.ax;
			ay_r <= col.ay;
			bx_r <= col.bx;
			by_r <= col.by;
			drx_r <= col.drx;
			dry_r <= col.dry;
		end else if (state == DIV_RUN) begin
			for (int i = 0; i < 4; i++) begin
				rem[i] <= rem_next[i];
				quot[i] <= {quot[i][`TMU_QR_W-2:0], q_bit[i]};
			end
		end
	end

	function automatic step_t pack_step(input logic pos, input logic [`TMU_QR_W-1:0] q,
		input logic [`TMU_SQH_W-1:0] r);
		step_t s;
		s.positive = pos;
		s.q = q;
		s.r = {{(`TMU_QR_W-`TMU_SQH_W){1'b0}}, r};
		return s;
	endfunction

	always_comb begin
		op.ax = ax_r;
		op.ay = ay_r;
		op.bx = bx_r;
		op.by = by_r;
		op.cx = pack_step(positive_r[0], quot[0], rem[0]);
		op.cy = pack_step(positive_r[1], quot[1], rem[1]);
		op.dx = pack_step(positive_r[2], quot[2], rem[2]);
		op.dy = pack_step(positive_r[3], quot[3], rem[3]);
		op.drx = drx_r;
		op.dry = dry_r;
	end

endmodule

/* source/tmu_vinterp.sv */
/*
 * Walks one column, emitting squareh points with y counting up.
 * x stays at drx. squareh must be nonzero and stable while busy.
 * Back-pressure on the output freezes all state.
 */
`timescale 1ns/1ns
`include "tmu_params.svh"

module tmu_vinterp import tmu_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic stb_i,
	output logic ack_o,
	input  interp_op_t op,
	input  logic [`TMU_SQH_W-1:0] squareh,
	output logic stb_o,
	input  logic ack_i,
	output fragment_t point,
	output logic busy
);

	walk_state_e state;
	walk_state_e state_next;
	logic load;
	logic next_point;
	logic last_point;

	logic signed [`TMU_PIX_W-1:0] x;
	logic signed [`TMU_PIX_W-1:0] y;
	logic [`TMU_SQH_W-1:0] remaining;

	logic [`TMU_COORD_W-1:0] init_v [4];
	step_t step_r [4];
	logic [`TMU_COORD_W-1:0] coord [4];

	// Steps are held locally once the divider is released
	always_ff @(posedge sys_clk) begin
		if (load) begin
			step_r[0] <= op.cx;
			step_r[1] <= op.cy;
			step_r[2] <= op.dx;
			step_r[3] <= op.dy;
			x <= op.drx;
		end
	end

	always_comb begin
		init_v[0] = op.ax;
		init_v[1] = op.ay;
		init_v[2] = op.bx;
		init_v[3] = op.by;
	end

	for (genvar g = 0; g < 4; g++) begin : g_edge
		tmu_edge_interp u_interp (
			.sys_clk(sys_clk),
			.load(load),
			.next_point(next_point),
			.init(init_v[g]),
			.step(step_r[g]),
			.divisor(squareh),
			.o(coord[g])
		);
	end

	// y and point counter
	always_ff @(posedge sys_clk) begin
		if (load) begin
			y <= op.dry;
			remaining <= squareh - 1'b1;
		end else if (next_point) begin
			y <= y + 1'b1;
			remaining <= remaining - 1'b1;
		end
	end

	assign last_point = (remaining == '0);

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= WALK_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		load = 1'b0;
		next_point = 1'b0;
		case (state)
			WALK_IDLE: if (stb_i) begin
				load = 1'b1;
				state_next = WALK_BUSY;
			end
			WALK_BUSY: if (ack_i) begin
				if (last_point)
					state_next = WALK_IDLE;
				else
					next_point = 1'b1;
			end
		endcase
	end

	assign ack_o = (state == WALK_IDLE);
	assign stb_o = (state == WALK_BUSY);
	assign busy = (state == WALK_BUSY);

	assign point = '{x: x, y: y, tsx: coord[0], tsy: coord[1], tex: coord[2], tey: coord[3]};

endmodule

/* source/tmu_vpipe.sv */
/*
 * Vertical interpolation stage: divide, walk the column, clip.
 * squareh must be nonzero and stable whenever busy is high.
 */
`timescale 1ns/1ns
`include "tmu_params.svh"

module tmu_vpipe import tmu_pkg::*; (
	input  logic sys_clk,
	input  logic sys_rst,
	input  logic in_stb,
	output logic in_ack,
	input  column_t col,
	input  logic [`TMU_SQH_W-1:0] squareh,
	output logic out_stb,
	input  logic out_ack,
	output fragment_t frag,
	output logic busy
);

	// Divider to walker
	logic op_stb;
	logic op_ack;
	interp_op_t op;

	// Walker to clip
	logic pt_stb;
	logic pt_ack;
	fragment_t point;

	logic busy_div;
	logic busy_walk;
	logic busy_clip;

	tmu_vdivops u_vdivops (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.stb_i(in_stb),
		.ack_o(in_ack),
		.col(col),
		.squareh(squareh),
		.stb_o(op_stb),
		.ack_i(op_ack),
		.op(op),
		.busy(busy_div)
	);

	tmu_vinterp u_vinterp (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.stb_i(op_stb),
		.ack_o(op_ack),
		.op(op),
		.squareh(squareh),
		.stb_o(pt_stb),
		.ack_i(pt_ack),
		.point(point),
		.busy(busy_walk)
	);

	tmu_clip u_clip (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.stb_i(pt_stb),
		.ack_o(pt_ack),
		.point(point),
		.stb_o(out_stb),
		.ack_i(out_ack),
		.frag(frag),
		.busy(busy_clip)
	);

	assign busy = busy_div | busy_walk | busy_clip;

endmodule

/* tests/tmu_vpipe_check.svh */
/*
 * Model queue and compare tasks, included inside the testbench module.
 * Expects the DUT types from tmu_pkg to be imported by the includer.
 */
`ifndef TMU_VPIPE_CHECK_SVH
`define TMU_VPIPE_CHECK_SVH

// Expected fragments in output order
fragment_t expected_q[$];
int errors = 0;
int checks = 0;

task automatic note_failure(input string what);
	errors++;
	$display("%0t: %s", $time, what);
endtask

task automatic check_fragment(input string name, input fragment_t actual,
	input fragment_t expected);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("Fail %s: got %h expected %h", name, actual, expected);
	end
endtask

task automatic check_idle(input string name, input logic actual, input logic expected);
	checks++;
	if (actual !== expected) begin
		errors++;
		$display("Fail %s: got %h expected %h", name, actual, expected);
	end
endtask

// Point k along one edge, init plus or minus floor(k*m/sqh), wrapped
function automatic logic [`TMU_COORD_W-1:0] edge_value(input logic [`TMU_COORD_W-1:0] init,
	input logic [`TMU_COORD_W-1:0] end_v, input int k, input int sqh);
	logic signed [`TMU_COORD_W-1:0] d;
	longint m;
	longint amount;
	d = end_v - init;
	m = (d < 0) ? -longint'(d) : longint'(d);
	amount = (longint'(k) * m) / sqh;
	if (d < 0)
		return init - amount[`TMU_COORD_W-1:0];
	return init + amount[`TMU_COORD_W-1:0];
endfunction

// Walk one column and queue the points that land on screen
task automatic model_column(input column_t c, input int sqh);
	fragment_t f;
	int xi;
	int yi;
	xi = int'(c.drx);
	for (int k = 0; k < sqh; k++) begin
		yi = int'(c.dry) + k;
		f.x = c.drx;
		f.y = `TMU_PIX_W'(yi);
		f.tsx = edge_value(c.ax, c.cx, k, sqh);
		f.tsy = edge_value(c.ay, c.cy, k, sqh);
		f.tex = edge_value(c.bx, c.dx, k, sqh);
		f.tey = edge_value(c.by, c.dy, k, sqh);
		if (xi >= 0 && xi < `TMU_HRES && yi >= 0 && yi < `TMU_VRES)
			expected_q.push_back(f);
	end
endtask

`endif

/* tests/tmu_vpipe_tb.sv */
/*
 * Random columns in batches that share one squareh, with the output ack
 * randomly withheld. squareh only changes while the pipeline is drained.
 */
`timescale 1ns/1ns
`include "tmu_params.svh"

module tmu_vpipe_tb import tmu_pkg::*; ();

	localparam int NUM_TESTS = 12;
	localparam int COLS_PER_TEST = 6;

	logic sys_clk;
	logic sys_rst;
	logic in_stb;
	logic in_ack;
	column_t col;
	logic [`TMU_SQH_W-1:0] squareh;
	logic out_stb;
	logic out_ack;
	fragment_t frag;
	logic busy;

	int sqh_list [NUM_TESTS];
	int limit = 0;
	logic limit_ready = 1'b0;
	int frag_count = 0;
	logic held = 1'b0;
	fragment_t held_frag;

	tmu_vpipe uut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.in_stb(in_stb),
		.in_ack(in_ack),
		.col(col),
		.squareh(squareh),
		.out_stb(out_stb),
		.out_ack(out_ack),
		.frag(frag),
		.busy(busy)
	);

	`include "tmu_vpipe_check.svh"

	always #50 sys_clk = ~sys_clk;

	function automatic logic [`TMU_COORD_W-1:0] any_coord();
		logic [31:0] r;
		r = $urandom;
		return r[`TMU_COORD_W-1:0];
	endfunction

	function automatic column_t random_column(input int sqh);
		column_t c;
		int pick;
		c.ax = any_coord();
		c.ay = any_coord();
		c.bx = any_coord();
		c.by = any_coord();
		c.cx = any_coord();
		c.cy = any_coord();
		c.dx = any_coord();
		c.dy = any_coord();
		c.drx = `TMU_PIX_W'(int'($urandom_range(764)) - 64);
		c.dry = `TMU_PIX_W'(int'($urandom_range(764)) - 64);
		pick = $urandom_range(7);
		case (pick)
			// Columns on or next to the screen edges
			0: c.drx = `TMU_PIX_W'($urandom_range(1) ? `TMU_HRES - 1 + $urandom_range(1)
				: -1 + int'($urandom_range(1)));
			1: c.dry = `TMU_PIX_W'($urandom_range(1) ? `TMU_VRES - sqh / 2 : -(sqh / 2));
			// Largest negative difference on one edge
			2: c.cx = c.ax ^ `TMU_COORD_W'(1 << (`TMU_COORD_W - 1));
			3: begin
				c.cx = c.ax;
				c.cy = c.ay;
				c.dx = c.bx;
				c.dy = c.by;
			end
			default: ;
		endcase
		return c;
	endfunction

	// Called on a falling edge, returns on the falling edge after the transfer
	task automatic send_column(input column_t c);
		in_stb = 1'b1;
		col = c;
		while (in_ack !== 1'b1)
			@(negedge sys_clk);
		@(negedge sys_clk);
		in_stb = 1'b0;
		check_idle("busy", busy, 1'b1);
	endtask

	task automatic run_test(input int t);
		column_t c;
		int errs_before;
		int frags_before;
		errs_before = errors;
		frags_before = frag_count;
		squareh = `TMU_SQH_W'(sqh_list[t]);
		for (int i = 0; i < COLS_PER_TEST; i++) begin
			c = random_column(sqh_list[t]);
			model_column(c, sqh_list[t]);
			send_column(c);
		end
		while (busy !== 1'b0)
			@(negedge sys_clk);
		check_idle("out_stb", out_stb, 1'b0);
		check_idle("in_ack", in_ack, 1'b1);
		if (expected_q.size() != 0)
			note_failure($sformatf("%0d expected fragments never came out", expected_q.size()));
		expected_q.delete();
		$display("test %0d: squareh %0d, %0d fragments, %0s", t, sqh_list[t],
			frag_count - frags_before,
			(errors == errs_before) ? "ok" : $sformatf("%0d problems", errors - errs_before));
	endtask

	// Random output acceptance and hold check
	always @(negedge sys_clk) begin
		if (held) begin
			if (out_stb !== 1'b1)
				note_failure("out_stb dropped before the fragment was accepted");
			else
				check_fragment("frag (held)", frag, held_frag);
		end
		out_ack = ($urandom_range(99) < 70);
		held = 1'b0;
		if (out_stb === 1'b1) begin
			if (out_ack) begin
				frag_count++;
				if (expected_q.size() == 0)
					note_failure("a fragment came out that the model did not expect");
				else
					check_fragment("frag", frag, expected_q.pop_front());
			end else begin
				held = 1'b1;
				held_frag = frag;
			end
		end
	end

	initial begin
		void'($urandom(14252));
		sys_clk = 1'b0;
		sys_rst = 1'b1;
		in_stb = 1'b0;
		col = '0;
		squareh = 1;
		out_ack = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			// First batch exercises the single-point column
			sqh_list[t] = (t == 0) ? 1 : int'($urandom_range(40, 1));
			limit += COLS_PER_TEST * (sqh_list[t] + 20) * 4;
		end
		limit_ready = 1'b1;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("%0d tests, %0d fragments, %0d checks, %0d errors",
			NUM_TESTS, frag_count, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		wait (limit_ready);
		repeat (limit) @(posedge sys_clk);
		$display("Timeout: the pipeline did not drain within %0d cycles", limit);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule
